/* rtl/common_defs.svh */
`ifndef COMMON_DEFS_SVH
`define COMMON_DEFS_SVH

// one and one half in q8.24
`define FP_ONE 32'sh0100_0000
`define FP_HALF 32'sh0080_0000

// same two constants in q11.21, screen space
`define FP_ONE_Q11_21 32'sh0020_0000
`define FP_HALF_Q11_21 32'sh0010_0000

`endif

/* rtl/vector_pkg.sv */
package vector_pkg;

    // q8.24 signed fixed point, one is 2^24
    typedef logic signed [31:0] fp;

    // three component vector, x in the top word
    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // pixel scanner states
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DONE
    } scan_state_t;

    // q8.24 product
    // full 64-bit signed product, drop 24 fraction bits, keep low word
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return fp'(prod >>> 24);
    endfunction

    // q11.21 product for screen space values
    function automatic fp fp_mul_q11_21(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return fp'(prod >>> 21);
    endfunction

    // dot product, each term truncated on its own
    function automatic fp vec3_dot(input vec3 a, input vec3 b);
        fp sum;
        sum = fp_mul(a.x, b.x);
        sum = sum + fp_mul(a.y, b.y);
        sum = sum + fp_mul(a.z, b.z);
        return sum;
    endfunction

    // cross product a x b
    function automatic vec3 vec3_cross(input vec3 a, input vec3 b);
        vec3 c;
        c.x = fp_mul(a.y, b.z) - fp_mul(a.z, b.y);
        c.y = fp_mul(a.z, b.x) - fp_mul(a.x, b.z);
        c.z = fp_mul(a.x, b.y) - fp_mul(a.y, b.x);
        return c;
    endfunction

endpackage

/* rtl/pixel_scanner.sv */
`timescale 1ns/100ps

module pixel_scanner import vector_pkg::*; #(
    parameter int H_RES = 640,
    parameter int V_RES = 480,
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic credit_return,
    output logic pix_valid,
    output logic frame_done,
    output logic [15:0] pix_x,
    output logic [15:0] pix_y
);

    // enough bits to hold a full set of credits
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    scan_state_t state;
    logic [CW-1:0] credits;
    logic issue;
    logic last_x;
    logic last_y;

    // one pixel per cycle while running and holding a credit
    assign issue = (state == SCAN_RUN) && (credits != '0);
    assign pix_valid = issue;

    // counters are the coordinates of the pixel on offer
    assign last_x = (pix_x == 16'(H_RES - 1));
    assign last_y = (pix_y == 16'(V_RES - 1));

    // done from the cycle after the last issue until next start
    assign frame_done = (state == SCAN_DONE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= SCAN_IDLE;
            credits <= CW'(FIFO_DEPTH);
            pix_x <= '0;
            pix_y <= '0;
        end else begin
            // start only honoured outside a running frame
            if (start && (state != SCAN_RUN)) begin
                state <= SCAN_RUN;
                credits <= CW'(FIFO_DEPTH);
                pix_x <= '0;
                pix_y <= '0;
            end else begin
                // spend on issue, refill on pop, both may coincide
                credits <= credits + CW'(credit_return) - CW'(issue);
                if (issue) begin
                    // raster order, x fastest
                    if (last_x) begin
                        pix_x <= '0;
                        if (last_y) begin
                            pix_y <= '0;
                            state <= SCAN_DONE;
                        end else begin
                            pix_y <= pix_y + 16'd1;
                        end
                    end else begin
                        pix_x <= pix_x + 16'd1;
                    end
                end
            end
        end
    end

endmodule

/* rtl/inv_sqrt.sv */
`timescale 1ns/100ps

`include "common_defs.svh"

module inv_sqrt import vector_pkg::*; (
    input logic clk,
    input logic rst,
    input logic valid_in,
    input fp x,
    output logic valid_out,
    output fp inv_sqrt
);

    // 1.5 in q8.24
    localparam fp THREE_HALVES = `FP_ONE + `FP_HALF;

    // newton factor 1.5 - 0.5*x*y*y
    // y squared first, then times x, then halved
    function automatic fp newton_factor(input fp xv, input fp yv);
        fp y_sq;
        fp xy_sq;
        y_sq = fp_mul(yv, yv);
        xy_sq = fp_mul(xv, y_sq);
        return THREE_HALVES - fp_mul(`FP_HALF, xy_sq);
    endfunction

    logic [4:0] lead;
    int k;
    int shift;
    fp seed;

    logic v1;
    logic v2;
    logic v3;
    fp x_s1;
    fp x_s2;
    fp y0;
    fp y1;
    fp y1_s3;
    fp f2;

    // leading one over the magnitude bits, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < 31; i++) begin
            if (x[i]) begin
                lead = 5'(i);
            end
        end
        // exponent relative to the binary point at bit 24
        k = int'(lead) - 24;
        // arithmetic shift rounds k/2 down, also for negative k
        shift = 24 - (k >>> 1);
        // tiny inputs would push the seed past the q8.24 range
        if (shift > 30) begin
            shift = 30;
        end
        // zero or negative input gives zero, which newton keeps at zero
        if (x > 0) begin
            seed = fp'(1) << shift;
        end else begin
            seed = '0;
        end
    end

    // valid chain, four stages
    always_ff @(posedge clk) begin
        if (!rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            v1 <= valid_in;
            v2 <= v1;
            v3 <= v2;
            valid_out <= v3;
        end
    end

    // datapath, free running
    always_ff @(posedge clk) begin
        // stage 1 seed
        x_s1 <= x;
        y0 <= seed;
        // stage 2 first newton step complete
        x_s2 <= x_s1;
        y1 <= fp_mul(y0, newton_factor(x_s1, y0));
        // stage 3 factor for the second step
        y1_s3 <= y1;
        f2 <= newton_factor(x_s2, y1);
        // stage 4 second step
        inv_sqrt <= fp_mul(y1_s3, f2);
    end

endmodule

/* rtl/ray_generator.sv */
`timescale 1ns/100ps

`include "common_defs.svh"

module ray_generator import vector_pkg::*; #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input logic clk,
    input logic rst,
    input logic pix_valid,
    input logic [15:0] pix_x,
    input logic [15:0] pix_y,
    input fp cam_fwd_x,
    input fp cam_fwd_y,
    input fp cam_fwd_z,
    input fp cam_right_x,
    input fp cam_right_y,
    input fp cam_right_z,
    output logic ray_valid,
    output fp ray_x,
    output fp ray_y,
    output fp ray_z,
    output logic [15:0] ray_px,
    output logic [15:0] ray_py
);

    // 2/H_RES and 2/V_RES in q11.21, truncated
    localparam fp SCALE_X = fp'((longint'(2) <<< 21) / H_RES);
    localparam fp SCALE_Y = fp'((longint'(2) <<< 21) / V_RES);
    // H_RES/V_RES in q8.24
    localparam fp ASPECT = fp'((longint'(H_RES) <<< 24) / V_RES);

    vec3 cam_fwd;
    vec3 cam_right;
    vec3 cam_up;

    fp sx_q;
    fp sy_q;
    fp sx_ndc;

    logic v1;
    logic v2;
    logic v3;
    fp ndc_x;
    fp ndc_y;
    vec3 view;
    vec3 vec_s3;
    fp mag_sq;
    logic [15:0] px_s1;
    logic [15:0] py_s1;
    logic [15:0] px_s2;
    logic [15:0] py_s2;
    logic [15:0] px_s3;
    logic [15:0] py_s3;

    // delay line matching the inv_sqrt latency
    vec3 vec_dly [4];
    logic [15:0] px_dly [4];
    logic [15:0] py_dly [4];

    logic inv_valid;
    fp inv_len;

    // camera vectors held steady for a frame
    assign cam_fwd = '{x: cam_fwd_x, y: cam_fwd_y, z: cam_fwd_z};
    assign cam_right = '{x: cam_right_x, y: cam_right_y, z: cam_right_z};
    // up is right x forward
    assign cam_up = vec3_cross(cam_right, cam_fwd);

    // pixel integers into q11.21
    assign sx_q = fp'(pix_x) <<< 21;
    assign sy_q = fp'(pix_y) <<< 21;
    // (x + 0.5) * 2/H_RES - 1, still q11.21
    assign sx_ndc = fp_mul_q11_21(sx_q + `FP_HALF_Q11_21, SCALE_X) - `FP_ONE_Q11_21;

    always_ff @(posedge clk) begin
        if (!rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= pix_valid;
            v2 <= v1;
            v3 <= v2;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 ndc, shift by 3 moves q11.21 to q8.24
        ndc_x <= fp_mul(sx_ndc <<< 3, ASPECT);
        ndc_y <= (`FP_ONE_Q11_21 - fp_mul_q11_21(sy_q + `FP_HALF_Q11_21, SCALE_Y)) <<< 3;
        px_s1 <= pix_x;
        py_s1 <= pix_y;
        // stage 2 view vector, camera looks down -forward
        view.x <= fp_mul(ndc_x, cam_right.x) + fp_mul(ndc_y, cam_up.x) - cam_fwd.x;
        view.y <= fp_mul(ndc_x, cam_right.y) + fp_mul(ndc_y, cam_up.y) - cam_fwd.y;
        view.z <= fp_mul(ndc_x, cam_right.z) + fp_mul(ndc_y, cam_up.z) - cam_fwd.z;
        px_s2 <= px_s1;
        py_s2 <= py_s1;
        // stage 3 squared length, vector kept for the scale stage
        mag_sq <= vec3_dot(view, view);
        vec_s3 <= view;
        px_s3 <= px_s2;
        py_s3 <= py_s2;
        // stages 4 to 7 alongside inv_sqrt
        vec_dly[0] <= vec_s3;
        px_dly[0] <= px_s3;
        py_dly[0] <= py_s3;
        for (int i = 1; i < 4; i++) begin
            vec_dly[i] <= vec_dly[i-1];
            px_dly[i] <= px_dly[i-1];
            py_dly[i] <= py_dly[i-1];
        end
        // stage 8 scale to unit length
        ray_x <= fp_mul(vec_dly[3].x, inv_len);
        ray_y <= fp_mul(vec_dly[3].y, inv_len);
        ray_z <= fp_mul(vec_dly[3].z, inv_len);
        ray_px <= px_dly[3];
        ray_py <= py_dly[3];
    end

    // 1/|v| over four cycles
    inv_sqrt u_inv_sqrt (
        .clk(clk),
        .rst(rst),
        .valid_in(v3),
        .x(mag_sq),
        .valid_out(inv_valid),
        .inv_sqrt(inv_len)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            ray_valid <= 1'b0;
        end else begin
            ray_valid <= inv_valid;
        end
    end

endmodule

/* rtl/ray_fifo.sv */
`timescale 1ns/100ps

module ray_fifo import vector_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic rst,
    input logic ray_valid,
    input logic out_ready,
    input fp ray_x,
    input fp ray_y,
    input fp ray_z,
    input logic [15:0] ray_px,
    input logic [15:0] ray_py,
    output logic out_valid,
    output logic credit_return,
    output fp out_x,
    output fp out_y,
    output fp out_z,
    output logic [15:0] out_px,
    output logic [15:0] out_py
);

    // three fp words plus two 16-bit tags
    localparam int W = 3 * 32 + 2 * 16;
    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [W-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic pop;

    assign out_valid = (count != '0);
    assign pop = out_valid && out_ready;
    // one credit back to the scanner per pop
    assign credit_return = pop;

    // head entry straight from storage
    assign {out_x, out_y, out_z, out_px, out_py} = mem[rd_ptr];

    // storage, no room check since credits bound occupancy
    always_ff @(posedge clk) begin
        if (ray_valid) begin
            mem[wr_ptr] <= {ray_x, ray_y, ray_z, ray_px, ray_py};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // pointers wrap at depth, which need not be a power of two
            if (ray_valid) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            end
            count <= count + CW'(ray_valid) - CW'(pop);
        end
    end

endmodule

/* rtl/ray_frame_top.sv */
`timescale 1ns/100ps

module ray_frame_top import vector_pkg::*; #(
    parameter int H_RES = 640,
    parameter int V_RES = 480,
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic rst,
    input logic start,
    input fp cam_fwd_x,
    input fp cam_fwd_y,
    input fp cam_fwd_z,
    input fp cam_right_x,
    input fp cam_right_y,
    input fp cam_right_z,
    input logic out_ready,
    output logic out_valid,
    output fp out_x,
    output fp out_y,
    output fp out_z,
    output logic [15:0] out_px,
    output logic [15:0] out_py,
    output logic frame_done
);

    // scanner to generator
    logic pix_valid;
    logic [15:0] pix_x;
    logic [15:0] pix_y;

    // generator to queue
    logic ray_valid;
    fp ray_x;
    fp ray_y;
    fp ray_z;
    logic [15:0] ray_px;
    logic [15:0] ray_py;

    // queue back to scanner
    logic credit_return;

    pixel_scanner #(
        .H_RES(H_RES),
        .V_RES(V_RES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_scanner (
        .clk(clk),
        .rst(rst),
        .start(start),
        .credit_return(credit_return),
        .pix_valid(pix_valid),
        .frame_done(frame_done),
        .pix_x(pix_x),
        .pix_y(pix_y)
    );

    // fixed eight cycle pipeline, never stalls
    ray_generator #(
        .H_RES(H_RES),
        .V_RES(V_RES)
    ) u_generator (
        .clk(clk),
        .rst(rst),
        .pix_valid(pix_valid),
        .pix_x(pix_x),
        .pix_y(pix_y),
        .cam_fwd_x(cam_fwd_x),
        .cam_fwd_y(cam_fwd_y),
        .cam_fwd_z(cam_fwd_z),
        .cam_right_x(cam_right_x),
        .cam_right_y(cam_right_y),
        .cam_right_z(cam_right_z),
        .ray_valid(ray_valid),
        .ray_x(ray_x),
        .ray_y(ray_y),
        .ray_z(ray_z),
        .ray_px(ray_px),
        .ray_py(ray_py)
    );

    ray_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .ray_valid(ray_valid),
        .out_ready(out_ready),
        .ray_x(ray_x),
        .ray_y(ray_y),
        .ray_z(ray_z),
        .ray_px(ray_px),
        .ray_py(ray_py),
        .out_valid(out_valid),
        .credit_return(credit_return),
        .out_x(out_x),
        .out_y(out_y),
        .out_z(out_z),
        .out_px(out_px),
        .out_py(out_py)
    );

endmodule

/* verification/ray_frame_tb.sv */
`timescale 1ns/100ps

`include "common_defs.svh"

module ray_frame_tb import vector_pkg::*; ;

    localparam int H_RES = 8;
    localparam int V_RES = 6;
    localparam int FIFO_DEPTH = 4;
    localparam int PIXELS = H_RES * V_RES;
    localparam int FRAMES = 4;
    localparam int HOLD_CYCLES = 100;
    localparam int CYCLE_LIMIT = FRAMES * PIXELS * 20 + 200;

    // screen scale 2/res in q11.21 and aspect in q8.24, truncated
    localparam fp SCALE_X = fp'(64'd4194304 / H_RES);
    localparam fp SCALE_Y = fp'(64'd4194304 / V_RES);
    localparam fp ASPECT = fp'((64'(H_RES) * 64'd16777216) / V_RES);

    // out_ready modes
    localparam int READY_ON = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_HOLD = 2;

    logic clk;
    logic rst;
    logic start;
    logic out_ready;
    vec3 cam_fwd;
    vec3 cam_right;
    logic out_valid;
    fp out_x;
    fp out_y;
    fp out_z;
    logic [15:0] out_px;
    logic [15:0] out_py;
    logic frame_done;

    int ready_mode;
    int total_pops;
    int cycles;

    // comparator scratch
    int cmp_idx;
    logic [15:0] cmp_px;
    logic [15:0] cmp_py;
    vec3 cmp_dir;

    ray_frame_top #(
        .H_RES(H_RES),
        .V_RES(V_RES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk(clk),
        .rst(rst),
        .start(start),
        .cam_fwd_x(cam_fwd.x),
        .cam_fwd_y(cam_fwd.y),
        .cam_fwd_z(cam_fwd.z),
        .cam_right_x(cam_right.x),
        .cam_right_y(cam_right.y),
        .cam_right_z(cam_right.z),
        .out_ready(out_ready),
        .out_valid(out_valid),
        .out_x(out_x),
        .out_y(out_y),
        .out_z(out_z),
        .out_px(out_px),
        .out_py(out_py),
        .frame_done(frame_done)
    );

    always #2 clk = ~clk;

    // first error ends the run
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // 1/sqrt(x), power of two seed then two newton steps
    function automatic fp model_inv_sqrt(input fp x);
        int lead;
        int k;
        int half_k;
        int sh;
        fp y;
        if (x <= 0) begin
            return '0;
        end
        lead = 30;
        while (!x[lead]) begin
            lead = lead - 1;
        end
        k = lead - 24;
        // k/2 rounded toward minus infinity
        half_k = (k >= 0) ? k / 2 : -((1 - k) / 2);
        sh = 24 - half_k;
        if (sh > 30) begin
            sh = 30;
        end
        y = fp'(32'sd1 << sh);
        for (int n = 0; n < 2; n++) begin
            y = fp_mul(y, (`FP_ONE + `FP_HALF) - fp_mul(`FP_HALF, fp_mul(x, fp_mul(y, y))));
        end
        return y;
    endfunction

    // unit ray for one pixel under the given camera
    function automatic vec3 expected_ray(input int px, input int py, input vec3 fwd,
                                         input vec3 right);
        vec3 up;
        vec3 view;
        vec3 dir;
        fp sx;
        fp nx;
        fp ny;
        fp inv_len;
        up = vec3_cross(right, fwd);
        // pixel centre to [-1, 1], q11.21 then times 8 into q8.24
        sx = fp_mul_q11_21(fp'(px * (1 << 21)) + `FP_HALF_Q11_21, SCALE_X) - `FP_ONE_Q11_21;
        nx = fp_mul(sx * 8, ASPECT);
        ny = (`FP_ONE_Q11_21 - fp_mul_q11_21(fp'(py * (1 << 21)) + `FP_HALF_Q11_21,
                                             SCALE_Y)) * 8;
        view.x = fp_mul(nx, right.x) + fp_mul(ny, up.x) - fwd.x;
        view.y = fp_mul(nx, right.y) + fp_mul(ny, up.y) - fwd.y;
        view.z = fp_mul(nx, right.z) + fp_mul(ny, up.z) - fwd.z;
        inv_len = model_inv_sqrt(vec3_dot(view, view));
        dir.x = fp_mul(view.x, inv_len);
        dir.y = fp_mul(view.y, inv_len);
        dir.z = fp_mul(view.z, inv_len);
        return dir;
    endfunction

    // unit vector along one axis, optionally negated
    function automatic vec3 axis_vector(input int axis, input bit neg);
        vec3 v;
        fp mag;
        mag = neg ? -`FP_ONE : `FP_ONE;
        v = '0;
        case (axis)
            0: v.x = mag;
            1: v.y = mag;
            default: v.z = mag;
        endcase
        return v;
    endfunction

    // two distinct random axes for right and forward
    // right never along x, so the camera differs from the first frame
    task automatic pick_camera();
        int r_axis;
        int f_axis;
        r_axis = 1 + ($urandom % 2);
        f_axis = (r_axis + 1 + ($urandom % 2)) % 3;
        cam_right <= axis_vector(r_axis, $urandom % 2);
        cam_fwd <= axis_vector(f_axis, $urandom % 2);
    endtask

    // one full frame, optional hold of out_ready right after start
    task automatic run_frame(input int mode, input bit hold_first);
        int target;
        bit seen_valid;
        target = total_pops + PIXELS;
        ready_mode <= hold_first ? READY_HOLD : mode;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_value("frame_done", frame_done, 0);
        if (hold_first) begin
            seen_valid = 1'b0;
            repeat (HOLD_CYCLES - 2) begin
                @(posedge clk);
                // once a ray is queued it stays visible
                if (seen_valid) begin
                    check_value("out_valid", out_valid, 1);
                end
                if (out_valid) begin
                    seen_valid = 1'b1;
                end
            end
            check_value("out_valid", out_valid, 1);
            // credits drained, scanner stalled mid frame
            check_value("frame_done", frame_done, 0);
            ready_mode <= mode;
        end
        while (total_pops < target) begin
            @(posedge clk);
        end
        check_value("frame_done", frame_done, 1);
        // queue drained, no extra rays
        check_value("out_valid", out_valid, 0);
    endtask

    // consumer side ready
    always @(posedge clk) begin
        case (ready_mode)
            READY_ON: out_ready <= 1'b1;
            READY_RANDOM: out_ready <= 1'($urandom % 2);
            default: out_ready <= 1'b0;
        endcase
    end

    // every pop against the raster order model
    always @(posedge clk) begin
        if (rst && out_valid && out_ready) begin
            cmp_idx = total_pops % PIXELS;
            cmp_px = 16'(cmp_idx % H_RES);
            cmp_py = 16'(cmp_idx / H_RES);
            cmp_dir = expected_ray(cmp_px, cmp_py, cam_fwd, cam_right);
            check_value("out_px", out_px, cmp_px);
            check_value("out_py", out_py, cmp_py);
            check_value("out_x", out_x, cmp_dir.x);
            check_value("out_y", out_y, cmp_dir.y);
            check_value("out_z", out_z, cmp_dir.z);
            total_pops <= total_pops + 1;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(32'hddb25657));
        clk = 1'b0;
        rst = 1'b0;
        start = 1'b0;
        out_ready = 1'b0;
        ready_mode = READY_ON;
        total_pops = 0;
        cycles = 0;
        // first camera, looking along z
        cam_right = axis_vector(0, 1'b0);
        cam_fwd = axis_vector(2, 1'b0);

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        // fixed camera, consumer always ready
        run_frame(READY_ON, 1'b0);
        // random back-pressure
        run_frame(READY_RANDOM, 1'b0);
        // consumer stalled after start
        run_frame(READY_ON, 1'b1);
        // new camera for a fresh frame
        pick_camera();
        run_frame(READY_RANDOM, 1'b0);

        repeat (20) @(posedge clk);
        if (total_pops == FRAMES * PIXELS) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Wrong number of rays popped: %0d instead of %0d",
                     total_pops, FRAMES * PIXELS);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/vector_pkg.sv
rtl/pixel_scanner.sv
rtl/inv_sqrt.sv
rtl/ray_generator.sv
rtl/ray_fifo.sv
rtl/ray_frame_top.sv
verification/ray_frame_tb.sv

/* Bender.yml */
package:
  name: ray_frame

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vector_pkg.sv
      - rtl/pixel_scanner.sv
      - rtl/inv_sqrt.sv
      - rtl/ray_generator.sv
      - rtl/ray_fifo.sv
      - rtl/ray_frame_top.sv
      - target: test
        files:
          - verification/ray_frame_tb.sv
